// File: rtl/loopback_defs.svh
// Widths, depths and control field bit positions
// for the Ethernet loopback client receive path
`ifndef LOOPBACK_DEFS_SVH
`define LOOPBACK_DEFS_SVH

// --------------------
// Receive beat geometry
// --------------------

// 64-bit lanes per beat
`define LB_WORDS            4
`define LB_DATA_W           (64*`LB_WORDS)

// Unused byte count in the last beat
`define LB_EMPTY_W          5

// MAC error vector
`define LB_ERR_W            6

// --------------------
// FIFO word control field
// --------------------
`define LB_CTRL_W           16
`define LB_CTRL_SOP_POS     0
`define LB_CTRL_EOP_POS     1
`define LB_CTRL_ERR_POS     2
`define LB_CTRL_EMPTY_POS   8

// --------------------
// FIFO and statistics
// --------------------

// 16 entries
`define LB_FIFO_AW          4
`define LB_FIFO_DEPTH       (1 << `LB_FIFO_AW)

// Packet counter width, saturates at all ones
`define LB_STAT_W           8

`endif

// File: rtl/eth_stream_pkg.sv
// Receive stream beat types: data, control field, empty count
// and MAC error vector
`include "loopback_defs.svh"

package eth_stream_pkg;

    // One beat of frame data
    typedef logic [`LB_DATA_W-1:0] beat_data_t;

    // Packed sop, eop, error and empty bits stored beside the data
    typedef logic [`LB_CTRL_W-1:0] beat_ctrl_t;

    // Unused bytes in the end of packet beat
    typedef logic [`LB_EMPTY_W-1:0] beat_empty_t;

    // Error bits reported by the MAC
    typedef logic [`LB_ERR_W-1:0] mac_err_t;

endpackage

// File: rtl/eth_stat_pkg.sv
// Statistics counter and FIFO pointer types
`include "loopback_defs.svh"

package eth_stat_pkg;

    // Saturating packet counter
    typedef logic [`LB_STAT_W-1:0] stat_cnt_t;

    // FIFO pointer, top bit is the wrap flag
    typedef logic [`LB_FIFO_AW:0] fifo_ptr_t;

endpackage

// File: rtl/rx_frame_packer.sv
// Receive beat register and control field packer
`timescale 1ns/100ps
`include "loopback_defs.svh"

module rx_frame_packer (
    input  logic                      i_clk_w,
    input  logic                      i_rst_n,
    input  logic                      i_valid,
    input  logic                      i_sop,
    input  logic                      i_eop,
    input  eth_stream_pkg::beat_empty_t i_empty,
    input  eth_stream_pkg::beat_data_t  i_data,
    input  eth_stream_pkg::mac_err_t    i_error,
    output logic                      o_wr_valid,
    output eth_stream_pkg::beat_data_t  o_wr_data,
    output eth_stream_pkg::beat_ctrl_t  o_wr_ctrl
);

    eth_stream_pkg::beat_ctrl_t beat_ctrl;

    // Unused control bits stay zero
    always_comb begin
        beat_ctrl                                       = '0;
        beat_ctrl[`LB_CTRL_SOP_POS]                     = i_sop;
        beat_ctrl[`LB_CTRL_EOP_POS]                     = i_eop;
        beat_ctrl[`LB_CTRL_ERR_POS]                     = |i_error;
        beat_ctrl[`LB_CTRL_EMPTY_POS +: `LB_EMPTY_W]    = i_empty;
    end

    always_ff @(posedge i_clk_w) begin
        if (!i_rst_n) begin
            o_wr_valid <= 1'b0;
        end else begin
            o_wr_valid <= i_valid;
        end
    end

    // Payload only moves on a valid beat
    always_ff @(posedge i_clk_w) begin
        if (i_valid) begin
            o_wr_data <= i_data;
            o_wr_ctrl <= beat_ctrl;
        end
    end

    // Packet markers from the MAC only come with a valid beat
    a_marker_needs_valid : assert property (
        @(posedge i_clk_w) disable iff (!i_rst_n)
        (i_sop || i_eop) |-> i_valid
    );

endmodule

// File: rtl/loopback_fifo.sv
// Synchronous loopback FIFO with read request, registered read data
// and sticky overflow and underflow flags
`timescale 1ns/100ps
`include "loopback_defs.svh"

module loopback_fifo (
    input  logic                      i_clk_w,
    input  logic                      i_rst_n,
    input  logic                      i_wr_valid,
    input  eth_stream_pkg::beat_data_t  i_wr_data,
    input  eth_stream_pkg::beat_ctrl_t  i_wr_ctrl,
    input  logic                      i_tx_req,
    input  logic                      i_stat_clr,
    output logic                      o_tx_valid,
    output eth_stream_pkg::beat_data_t  o_tx_data,
    output eth_stream_pkg::beat_ctrl_t  o_tx_ctrl,
    output logic                      o_wr_full_err,
    output logic                      o_rd_empty_err
);

    eth_stream_pkg::beat_data_t mem_data [`LB_FIFO_DEPTH];
    eth_stream_pkg::beat_ctrl_t mem_ctrl [`LB_FIFO_DEPTH];

    eth_stat_pkg::fifo_ptr_t wr_ptr;
    eth_stat_pkg::fifo_ptr_t rd_ptr;
    eth_stat_pkg::fifo_ptr_t occupancy;

    logic fifo_full;
    logic fifo_empty;
    logic wr_en;
    logic rd_en;

    // --------------------
    // Status
    // --------------------

    // Same index with opposite wrap bits means full
    assign fifo_full  = (wr_ptr[`LB_FIFO_AW] != rd_ptr[`LB_FIFO_AW]) &&
                        (wr_ptr[`LB_FIFO_AW-1:0] == rd_ptr[`LB_FIFO_AW-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign occupancy  = wr_ptr - rd_ptr;

    assign wr_en = i_wr_valid && !fifo_full;
    assign rd_en = i_tx_req && !fifo_empty;

    // --------------------
    // Pointers and flags
    // --------------------
    always_ff @(posedge i_clk_w) begin
        if (!i_rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            o_tx_valid     <= 1'b0;
            o_wr_full_err  <= 1'b0;
            o_rd_empty_err <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_tx_valid <= rd_en;

            // Clear wins over a new error on the same edge
            if (i_stat_clr) begin
                o_wr_full_err  <= 1'b0;
                o_rd_empty_err <= 1'b0;
            end else begin
                if (i_wr_valid && fifo_full) begin
                    o_wr_full_err <= 1'b1;
                end
                if (i_tx_req && fifo_empty) begin
                    o_rd_empty_err <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge i_clk_w) begin
        if (wr_en) begin
            mem_data[wr_ptr[`LB_FIFO_AW-1:0]] <= i_wr_data;
            mem_ctrl[wr_ptr[`LB_FIFO_AW-1:0]] <= i_wr_ctrl;
        end
        if (rd_en) begin
            o_tx_data <= mem_data[rd_ptr[`LB_FIFO_AW-1:0]];
            o_tx_ctrl <= mem_ctrl[rd_ptr[`LB_FIFO_AW-1:0]];
        end
    end

    // Pointer distance stays within the memory size
    a_occupancy_bound : assert property (
        @(posedge i_clk_w) disable iff (!i_rst_n)
        occupancy <= `LB_FIFO_DEPTH
    );

endmodule

// File: rtl/rx_pkt_stats.sv
// Saturating start, end and errored packet counters with clear
`timescale 1ns/100ps
`include "loopback_defs.svh"

module rx_pkt_stats (
    input  logic                    i_clk_w,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  logic                    i_sop,
    input  logic                    i_eop,
    input  eth_stream_pkg::mac_err_t  i_error,
    input  logic                    i_stat_clr,
    output logic                    o_stat_valid,
    output eth_stat_pkg::stat_cnt_t   o_stat_sop_cnt,
    output eth_stat_pkg::stat_cnt_t   o_stat_eop_cnt,
    output eth_stat_pkg::stat_cnt_t   o_stat_err_cnt
);

    logic sop_hit;
    logic eop_hit;
    logic err_hit;

    // Holds at all ones instead of wrapping
    function automatic eth_stat_pkg::stat_cnt_t sat_inc(input eth_stat_pkg::stat_cnt_t cnt);
        if (&cnt) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    assign sop_hit = i_valid && i_sop;
    assign eop_hit = i_valid && i_eop;
    // Error bits are only meaningful on the last beat
    assign err_hit = eop_hit && (|i_error);

    always_ff @(posedge i_clk_w) begin
        if (!i_rst_n || i_stat_clr) begin
            o_stat_sop_cnt <= '0;
            o_stat_eop_cnt <= '0;
            o_stat_err_cnt <= '0;
            o_stat_valid   <= 1'b0;
        end else begin
            if (sop_hit) begin
                o_stat_sop_cnt <= sat_inc(o_stat_sop_cnt);
            end
            if (eop_hit) begin
                o_stat_eop_cnt <= sat_inc(o_stat_eop_cnt);
            end
            if (err_hit) begin
                o_stat_err_cnt <= sat_inc(o_stat_err_cnt);
            end
            o_stat_valid <= eop_hit;
        end
    end

    // Counters only go down through a clear
    a_no_decrement : assert property (
        @(posedge i_clk_w) disable iff (!i_rst_n)
        !$past(i_stat_clr) |-> (o_stat_sop_cnt >= $past(o_stat_sop_cnt)) &&
                               (o_stat_eop_cnt >= $past(o_stat_eop_cnt)) &&
                               (o_stat_err_cnt >= $past(o_stat_err_cnt))
    );

endmodule

// File: rtl/eth_loopback_client.sv
// Loopback client receive side top level
// packer and FIFO path beside the packet statistics
`timescale 1ns/100ps

module eth_loopback_client (
    input  logic                      i_clk_w,
    input  logic                      i_rst_n,

    // MAC receive stream
    input  logic                      i_valid,
    input  logic                      i_sop,
    input  logic                      i_eop,
    input  eth_stream_pkg::beat_empty_t i_empty,
    input  eth_stream_pkg::beat_data_t  i_data,
    input  eth_stream_pkg::mac_err_t    i_error,

    // Transmit side read port
    input  logic                      i_tx_req,
    output logic                      o_tx_valid,
    output eth_stream_pkg::beat_data_t  o_tx_data,
    output eth_stream_pkg::beat_ctrl_t  o_tx_ctrl,

    // CSR
    input  logic                      i_stat_clr,
    output logic                      o_wr_full_err,
    output logic                      o_rd_empty_err,
    output logic                      o_stat_valid,
    output eth_stat_pkg::stat_cnt_t     o_stat_sop_cnt,
    output eth_stat_pkg::stat_cnt_t     o_stat_eop_cnt,
    output eth_stat_pkg::stat_cnt_t     o_stat_err_cnt
);

    logic                       wr_valid;
    eth_stream_pkg::beat_data_t wr_data;
    eth_stream_pkg::beat_ctrl_t wr_ctrl;

    rx_frame_packer u_packer (
        .i_clk_w    (i_clk_w),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_sop      (i_sop),
        .i_eop      (i_eop),
        .i_empty    (i_empty),
        .i_data     (i_data),
        .i_error    (i_error),
        .o_wr_valid (wr_valid),
        .o_wr_data  (wr_data),
        .o_wr_ctrl  (wr_ctrl)
    );

    loopback_fifo u_fifo (
        .i_clk_w        (i_clk_w),
        .i_rst_n        (i_rst_n),
        .i_wr_valid     (wr_valid),
        .i_wr_data      (wr_data),
        .i_wr_ctrl      (wr_ctrl),
        .i_tx_req       (i_tx_req),
        .i_stat_clr     (i_stat_clr),
        .o_tx_valid     (o_tx_valid),
        .o_tx_data      (o_tx_data),
        .o_tx_ctrl      (o_tx_ctrl),
        .o_wr_full_err  (o_wr_full_err),
        .o_rd_empty_err (o_rd_empty_err)
    );

    // Taps the raw receive stream, not the packed words
    rx_pkt_stats u_stats (
        .i_clk_w        (i_clk_w),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_valid),
        .i_sop          (i_sop),
        .i_eop          (i_eop),
        .i_error        (i_error),
        .i_stat_clr     (i_stat_clr),
        .o_stat_valid   (o_stat_valid),
        .o_stat_sop_cnt (o_stat_sop_cnt),
        .o_stat_eop_cnt (o_stat_eop_cnt),
        .o_stat_err_cnt (o_stat_err_cnt)
    );

endmodule

// File: verif/tb_eth_loopback_client.sv
// Directed testbench for the loopback client receive side
// clock, reset, watchdog, expected word model and test tasks
`timescale 1ns/100ps
`include "loopback_defs.svh"

module tb_eth_loopback_client;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int DRIVE_DELAY     = 2;
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int READ_WAIT_MAX   = 4;

    logic                        clk_w;
    logic                        rst_n;
    logic                        rx_valid;
    logic                        rx_sop;
    logic                        rx_eop;
    eth_stream_pkg::beat_empty_t rx_empty;
    eth_stream_pkg::beat_data_t  rx_data;
    eth_stream_pkg::mac_err_t    rx_error;
    logic                        tx_req;
    logic                        stat_clr;
    logic                        tx_valid;
    eth_stream_pkg::beat_data_t  tx_data;
    eth_stream_pkg::beat_ctrl_t  tx_ctrl;
    logic                        wr_full_err;
    logic                        rd_empty_err;
    logic                        stat_valid;
    eth_stat_pkg::stat_cnt_t     sop_cnt;
    eth_stat_pkg::stat_cnt_t     eop_cnt;
    eth_stat_pkg::stat_cnt_t     stat_err_cnt;

    // Expected FIFO contents, oldest first
    eth_stream_pkg::beat_data_t exp_data_q[$];
    eth_stream_pkg::beat_ctrl_t exp_ctrl_q[$];

    int          error_count;
    int          check_count;
    int          stat_pulses;
    int          words_read;

    eth_loopback_client dut (
        .i_clk_w(clk_w), .i_rst_n(rst_n),
        .i_valid(rx_valid), .i_sop(rx_sop), .i_eop(rx_eop),
        .i_empty(rx_empty), .i_data(rx_data), .i_error(rx_error),
        .i_tx_req(tx_req), .o_tx_valid(tx_valid), .o_tx_data(tx_data), .o_tx_ctrl(tx_ctrl),
        .i_stat_clr(stat_clr), .o_wr_full_err(wr_full_err), .o_rd_empty_err(rd_empty_err),
        .o_stat_valid(stat_valid), .o_stat_sop_cnt(sop_cnt), .o_stat_eop_cnt(eop_cnt),
        .o_stat_err_cnt(stat_err_cnt)
    );

    initial begin
        clk_w = 1'b0;
        forever #(CLK_PERIOD/2) clk_w = ~clk_w;
    end

    // Count end of packet reports between edges
    always @(negedge clk_w) begin
        if (rst_n && stat_valid) begin
            stat_pulses = stat_pulses + 1;
        end
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic compare_value(input string test, input string what,
                                 input logic [`LB_DATA_W-1:0] expected,
                                 input logic [`LB_DATA_W-1:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Fail %s: %s expected %0h actual %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    function automatic eth_stream_pkg::beat_data_t random_beat();
        eth_stream_pkg::beat_data_t d;
        for (int k = 0; k < `LB_DATA_W/32; k++) begin
            d[k*32 +: 32] = $urandom();
        end
        return d;
    endfunction

    // sop bit 0, eop bit 1, any error bit 2, empty count from bit 8
    function automatic eth_stream_pkg::beat_ctrl_t expected_ctrl(input logic sop, input logic eop,
            input eth_stream_pkg::mac_err_t err, input eth_stream_pkg::beat_empty_t empty);
        eth_stream_pkg::beat_ctrl_t c;
        c = '0;
        c[`LB_CTRL_SOP_POS] = sop;
        c[`LB_CTRL_EOP_POS] = eop;
        c[`LB_CTRL_ERR_POS] = (err != '0);
        c[`LB_CTRL_EMPTY_POS +: `LB_EMPTY_W] = empty;
        return c;
    endfunction

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_w);
            #DRIVE_DELAY;
            rx_valid = 1'b0;
            rx_sop   = 1'b0;
            rx_eop   = 1'b0;
            rx_empty = '0;
            rx_error = '0;
            tx_req   = 1'b0;
            stat_clr = 1'b0;
        end
    endtask

    task automatic send_beat(input logic sop, input logic eop,
                             input eth_stream_pkg::beat_empty_t empty,
                             input eth_stream_pkg::mac_err_t err);
        @(posedge clk_w);
        #DRIVE_DELAY;
        rx_valid = 1'b1;
        rx_sop   = sop;
        rx_eop   = eop;
        rx_empty = empty;
        rx_error = err;
        rx_data  = random_beat();
        // A full FIFO keeps its oldest words
        if (exp_data_q.size() < `LB_FIFO_DEPTH) begin
            exp_data_q.push_back(rx_data);
            exp_ctrl_q.push_back(expected_ctrl(sop, eop, err, empty));
        end
    endtask

    task automatic pulse_stat_clr();
        @(posedge clk_w);
        #DRIVE_DELAY;
        stat_clr = 1'b1;
        @(posedge clk_w);
        #DRIVE_DELAY;
        stat_clr = 1'b0;
    endtask

    task automatic read_word(input string test, output eth_stream_pkg::beat_ctrl_t got_ctrl);
        int waited;
        waited   = 0;
        got_ctrl = '0;
        @(posedge clk_w);
        #DRIVE_DELAY;
        tx_req = 1'b1;
        @(posedge clk_w);
        #DRIVE_DELAY;
        tx_req = 1'b0;
        while (!tx_valid && waited < READ_WAIT_MAX) begin
            @(posedge clk_w);
            #DRIVE_DELAY;
            waited++;
        end
        if (!tx_valid) begin
            $display("%s: no read data came back after a request", test);
            error_count++;
        end else if (exp_data_q.size() == 0) begin
            $display("%s: read data came back with no word expected", test);
            error_count++;
        end else begin
            words_read++;
            got_ctrl = tx_ctrl;
            compare_value(test, "data", exp_data_q.pop_front(), tx_data);
            compare_value(test, "ctrl", exp_ctrl_q.pop_front(), tx_ctrl);
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic single_beat_loopback();
        eth_stream_pkg::beat_ctrl_t got;
        send_beat(1'b1, 1'b1, 5'd3, 6'h00);
        drive_idle(2);
        read_word("single_beat_loopback", got);
        compare_value("single_beat_loopback", "sop bit", 1, got[`LB_CTRL_SOP_POS]);
        compare_value("single_beat_loopback", "eop bit", 1, got[`LB_CTRL_EOP_POS]);
        compare_value("single_beat_loopback", "error bit", 0, got[`LB_CTRL_ERR_POS]);
        compare_value("single_beat_loopback", "empty", 3, got[`LB_CTRL_EMPTY_POS +: `LB_EMPTY_W]);
    endtask

    task automatic multi_beat_error();
        eth_stream_pkg::beat_ctrl_t got;
        for (int i = 0; i < 4; i++) begin
            send_beat(i == 0, i == 3, (i == 3) ? 5'd7 : 5'd0, (i == 3) ? 6'h05 : 6'h00);
        end
        drive_idle(2);
        for (int i = 0; i < 4; i++) begin
            read_word("multi_beat_error", got);
            compare_value("multi_beat_error", "error bit", i == 3, got[`LB_CTRL_ERR_POS]);
        end
    endtask

    task automatic stats_counting();
        eth_stream_pkg::beat_ctrl_t got;
        pulse_stat_clr();
        stat_pulses = 0;
        for (int p = 0; p < 5; p++) begin
            send_beat(1'b1, 1'b1, 5'd0, (p == 1 || p == 3) ? 6'h21 : 6'h00);
        end
        drive_idle(3);
        compare_value("stats_counting", "sop count", 5, sop_cnt);
        compare_value("stats_counting", "eop count", 5, eop_cnt);
        compare_value("stats_counting", "error count", 2, stat_err_cnt);
        compare_value("stats_counting", "stat_valid pulses", 5, stat_pulses);
        // Drain the packets so the FIFO starts empty again
        repeat (5) read_word("stats_counting", got);
    endtask

    task automatic fifo_overflow();
        eth_stream_pkg::beat_ctrl_t got;
        eth_stat_pkg::fifo_ptr_t    returned;
        int                         start;
        for (int i = 0; i < 20; i++) begin
            send_beat(1'b1, 1'b1, 5'(i), 6'h00);
        end
        drive_idle(2);
        compare_value("fifo_overflow", "wr_full_err", 1, wr_full_err);
        start = words_read;
        repeat (`LB_FIFO_DEPTH) read_word("fifo_overflow", got);
        returned = eth_stat_pkg::fifo_ptr_t'(words_read - start);
        compare_value("fifo_overflow", "words returned", `LB_FIFO_DEPTH, returned);
    endtask

    task automatic underflow_and_clear();
        @(posedge clk_w);
        #DRIVE_DELAY;
        tx_req = 1'b1;
        @(posedge clk_w);
        #DRIVE_DELAY;
        tx_req = 1'b0;
        compare_value("underflow_and_clear", "tx_valid", 0, tx_valid);
        compare_value("underflow_and_clear", "rd_empty_err", 1, rd_empty_err);
        pulse_stat_clr();
        compare_value("underflow_and_clear", "wr_full_err", 0, wr_full_err);
        compare_value("underflow_and_clear", "rd_empty_err", 0, rd_empty_err);
        compare_value("underflow_and_clear", "sop count", 0, sop_cnt);
        compare_value("underflow_and_clear", "eop count", 0, eop_cnt);
        compare_value("underflow_and_clear", "error count", 0, stat_err_cnt);
    endtask

    initial begin
        void'($urandom(32'h612cbbfd));
        error_count = 0;
        check_count = 0;
        stat_pulses = 0;
        words_read  = 0;
        rst_n       = 1'b0;
        rx_valid    = 1'b0;
        rx_sop      = 1'b0;
        rx_eop      = 1'b0;
        rx_empty    = '0;
        rx_data     = '0;
        rx_error    = '0;
        tx_req      = 1'b0;
        stat_clr    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_w);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        drive_idle(2);
        single_beat_loopback();
        multi_beat_error();
        stats_counting();
        fifo_overflow();
        underflow_and_clear();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/eth_stream_pkg.sv
rtl/eth_stat_pkg.sv
rtl/rx_frame_packer.sv
rtl/loopback_fifo.sv
rtl/rx_pkt_stats.sv
rtl/eth_loopback_client.sv
verif/tb_eth_loopback_client.sv

// File: Makefile
# Verilator lint and simulation of the loopback client receive side

VERILATOR  ?= verilator
TOP        ?= tb_eth_loopback_client
DUT_TOP    ?= eth_loopback_client
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Testbench failed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(DUT_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
